/* hdl/pf_cfg_pkg.sv */
package pf_cfg_pkg;

    // Beat geometry of the snooped and forwarded streams
    localparam int DATA_BYTES = 8;                  // Bytes per beat

    // One stream beat of payload
    typedef logic [DATA_BYTES*8-1:0] data_t;

    // Byte enables, contiguous from byte 0
    typedef logic [DATA_BYTES-1:0] keep_t;

    // Valid bytes in one beat, 1..8
    typedef logic [3:0] beat_bytes_t;

    // Beat number inside a packet, bounds MAX_BEATS to 256
    typedef logic [7:0] beat_idx_t;

    // Packet length in bytes
    typedef logic [15:0] pkt_len_t;

    // Rejected plus overflowed packets
    typedef logic [15:0] drop_cnt_t;

endpackage

/* hdl/pf_rule_pkg.sv */
package pf_rule_pkg;

    // Rule word layout
    //   [31]    valid
    //   [23:16] byte offset in packet
    //   [15:8]  compare mask
    //   [7:0]   compare value
    typedef logic [31:0] rule_word_t;

    localparam int RULE_VALID_BIT = 31;
    localparam int RULE_OFS_LSB   = 16;             // Offset field, 8 bits
    localparam int RULE_MASK_LSB  = 8;              // Mask field, 8 bits
    localparam int RULE_VAL_LSB   = 0;              // Value field, 8 bits

    // Rule table index, so at most 16 rules
    typedef logic [3:0] rule_addr_t;

endpackage

/* hdl/pf_snooper.sv */
`timescale 1ns/1ps

module pf_snooper #(
    parameter int MAX_BEATS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  pf_cfg_pkg::data_t       sn_tdata,
    input  pf_cfg_pkg::keep_t       sn_tkeep,
    input  logic                    sn_tvalid,
    input  logic                    sn_tready,
    input  logic                    sn_tlast,
    input  logic                    slot_free,
    output logic                    beat_valid,
    output pf_cfg_pkg::data_t       beat_data,
    output pf_cfg_pkg::beat_idx_t   beat_idx,
    output pf_cfg_pkg::beat_bytes_t beat_bytes,
    output logic                    beat_last,
    output logic                    overflow
);

    typedef enum logic [1:0] {
        s_idle,                                     // Between packets, running
        s_pass,                                     // Admitted packet in flight
        s_skip,                                     // Ignoring rest of packet
        s_wait_start                                // Between packets, stopped
    } state_t;

    state_t                state;
    state_t                end_state;               // Where a packet end lands
    pf_cfg_pkg::beat_idx_t next_idx;
    pf_cfg_pkg::beat_idx_t cur_idx;
    logic                  link_beat;
    logic                  admit;
    logic                  take;

    // Count of valid bytes from a contiguous tkeep
    function automatic pf_cfg_pkg::beat_bytes_t keep_bytes(input pf_cfg_pkg::keep_t keep);
        pf_cfg_pkg::beat_bytes_t n;
        n = '0;
        for (int i = 0; i < pf_cfg_pkg::DATA_BYTES; i++) begin
            if (keep[i]) begin
                n = pf_cfg_pkg::beat_bytes_t'(i + 1);  // Highest set bit wins
            end
        end
        return n;
    endfunction

    assign link_beat = sn_tvalid & sn_tready;       // Observed transfer
    assign admit     = (state == s_idle) & start & slot_free;
    assign take      = link_beat & (admit | (state == s_pass));
    assign cur_idx   = (state == s_pass) ? next_idx : '0;
    assign end_state = start ? s_idle : s_wait_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= s_idle;
            next_idx   <= '0;
            beat_valid <= 1'b0;
            beat_idx   <= '0;
            beat_bytes <= '0;
            beat_last  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            beat_valid <= take;                     // One-cycle strobe per beat
            // First beat of a packet with no slot to land in
            overflow   <= link_beat & (state == s_idle) & start & ~slot_free;
            if (take) begin
                beat_idx   <= cur_idx;
                beat_bytes <= keep_bytes(sn_tkeep);
                beat_last  <= sn_tlast;
                if (32'(cur_idx) < MAX_BEATS) begin
                    next_idx <= cur_idx + 1'b1;
                end else begin
                    next_idx <= cur_idx;            // Stuck past the slot end
                end
            end
            case (state)
                s_idle, s_wait_start: begin
                    if (link_beat) begin
                        state <= sn_tlast ? end_state : (admit ? s_pass : s_skip);
                    end else begin
                        state <= end_state;         // Follow start between packets
                    end
                end
                s_pass, s_skip: begin
                    if (link_beat && sn_tlast) begin
                        state <= end_state;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Payload only, follows the strobe
    always_ff @(posedge clk) begin
        if (take) begin
            beat_data <= sn_tdata;
        end
    end

endmodule

/* hdl/pf_rule_matcher.sv */
`timescale 1ns/1ps

module pf_rule_matcher #(
    parameter int N_RULES = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pf_rule_pkg::rule_addr_t inst_wr_addr,
    input  pf_rule_pkg::rule_word_t inst_wr_data,
    input  logic                    inst_wr_en,
    input  logic                    beat_valid,
    input  pf_cfg_pkg::data_t       beat_data,
    input  pf_cfg_pkg::beat_idx_t   beat_idx,
    input  pf_cfg_pkg::beat_bytes_t beat_bytes,
    input  logic                    beat_last,
    input  logic                    overflow,
    output logic                    accept,
    output logic                    reject,
    output pf_cfg_pkg::drop_cnt_t   num_packets_dropped
);

    pf_rule_pkg::rule_word_t rules [N_RULES];
    logic [N_RULES-1:0]      hit;                   // Rules matched so far in packet
    logic [N_RULES-1:0]      hit_now;               // Including the current beat
    logic [N_RULES-1:0]      rule_ok;               // Invalid or matched
    logic [1:0]              drop_inc;
    logic [$bits(pf_cfg_pkg::drop_cnt_t):0] drop_sum;

    // Per-rule byte compare against the current beat
    for (genvar r = 0; r < N_RULES; r++) begin : g_rule
        logic [7:0] ofs;
        logic [7:0] mask;
        logic [7:0] val;
        logic [7:0] pkt_byte;
        logic       in_beat;

        assign ofs  = rules[r][pf_rule_pkg::RULE_OFS_LSB +: 8];
        assign mask = rules[r][pf_rule_pkg::RULE_MASK_LSB +: 8];
        assign val  = rules[r][pf_rule_pkg::RULE_VAL_LSB +: 8];
        // Byte lies in this beat and inside its valid bytes
        assign in_beat  = (beat_idx == {3'b000, ofs[7:3]}) && ({1'b0, ofs[2:0]} < beat_bytes);
        assign pkt_byte = beat_data[{ofs[2:0], 3'b000} +: 8];
        assign hit_now[r] = hit[r] | (in_beat & ((pkt_byte & mask) == (val & mask)));
        assign rule_ok[r] = ~rules[r][pf_rule_pkg::RULE_VALID_BIT] | hit_now[r];
    end

    // Verdict on the last beat, unreached offsets never hit
    assign accept = beat_valid & beat_last & (&rule_ok);
    assign reject = beat_valid & beat_last & ~(&rule_ok);

    assign drop_inc = {1'b0, reject} + {1'b0, overflow};
    assign drop_sum = {1'b0, num_packets_dropped} + drop_inc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_RULES; i++) begin
                rules[i] <= '0;                     // Empty table accepts all
            end
            hit                 <= '0;
            num_packets_dropped <= '0;
        end else begin
            for (int i = 0; i < N_RULES; i++) begin
                if (inst_wr_en && inst_wr_addr == pf_rule_pkg::rule_addr_t'(i)) begin
                    rules[i] <= inst_wr_data;
                end
            end
            if (beat_valid) begin
                hit <= beat_last ? '0 : hit_now;    // Fresh flags per packet
            end
            if (drop_sum[$bits(pf_cfg_pkg::drop_cnt_t)]) begin
                num_packets_dropped <= '1;          // Saturate
            end else begin
                num_packets_dropped <= drop_sum[$bits(pf_cfg_pkg::drop_cnt_t)-1:0];
            end
        end
    end

endmodule

/* hdl/pf_packet_buffer.sv */
`timescale 1ns/1ps

module pf_packet_buffer #(
    parameter int MAX_BEATS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    beat_valid,
    input  pf_cfg_pkg::data_t       beat_data,
    input  pf_cfg_pkg::beat_idx_t   beat_idx,
    input  pf_cfg_pkg::beat_bytes_t beat_bytes,
    input  logic                    beat_last,
    input  logic                    accept,
    input  logic                    rd_release,
    input  logic                    rd_en,
    input  pf_cfg_pkg::beat_idx_t   rd_addr,
    output logic                    slot_free,
    output logic                    rd_full,
    output pf_cfg_pkg::pkt_len_t    rd_len,
    output pf_cfg_pkg::data_t       rd_data
);

    localparam int AW = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;

    pf_cfg_pkg::data_t    mem [2][MAX_BEATS];       // Two packet slots
    pf_cfg_pkg::pkt_len_t len [2];                  // Byte length per slot
    logic [1:0]           full;
    logic                 wptr;                     // Slot being filled
    logic                 rptr;                     // Slot being forwarded
    logic                 in_slot;
    pf_cfg_pkg::pkt_len_t last_len;

    assign in_slot  = 32'(beat_idx) < MAX_BEATS;    // Longer packets are truncated
    assign last_len = in_slot ?
                      pf_cfg_pkg::pkt_len_t'({beat_idx, 3'b000}) +
                      pf_cfg_pkg::pkt_len_t'(beat_bytes) :
                      pf_cfg_pkg::pkt_len_t'(MAX_BEATS * pf_cfg_pkg::DATA_BYTES);

    // A commit this cycle moves the write side to the other slot
    assign slot_free = accept ? ~full[~wptr] : ~full[wptr];
    assign rd_full   = full[rptr];
    assign rd_len    = len[rptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 2'b00;
            wptr <= 1'b0;
            rptr <= 1'b0;
        end else begin
            if (accept) begin
                full[wptr] <= 1'b1;                 // Commit
                wptr       <= ~wptr;
            end
            if (rd_release) begin
                full[rptr] <= 1'b0;                 // Forwarded, hand slot back
                rptr       <= ~rptr;
            end
        end
    end

    // Rejected packet stays in place and gets overwritten
    always_ff @(posedge clk) begin
        if (beat_valid && in_slot) begin
            mem[wptr][beat_idx[AW-1:0]] <= beat_data;
        end
        if (beat_valid && beat_last) begin
            len[wptr] <= last_len;
        end
        if (rd_en) begin
            rd_data <= mem[rptr][rd_addr[AW-1:0]];  // One cycle read
        end
    end

endmodule

/* hdl/pf_forwarder.sv */
`timescale 1ns/1ps

module pf_forwarder #(
    parameter int MAX_BEATS = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_full,
    input  pf_cfg_pkg::pkt_len_t  rd_len,
    input  pf_cfg_pkg::data_t     rd_data,
    input  logic                  fwd_tready,
    output logic                  rd_en,
    output pf_cfg_pkg::beat_idx_t rd_addr,
    output logic                  rd_release,
    output pf_cfg_pkg::data_t     fwd_tdata,
    output pf_cfg_pkg::keep_t     fwd_tkeep,
    output logic                  fwd_tlast,
    output logic                  fwd_tvalid
);

    typedef enum logic [1:0] {
        s_idle,                                     // Waiting for a committed slot
        s_fetch,                                    // Memory read in progress
        s_present                                   // Beat on the bus
    } state_t;

    state_t                state;
    pf_cfg_pkg::beat_idx_t beat_cnt;                // Beat being sent
    pf_cfg_pkg::pkt_len_t  last_idx;
    pf_cfg_pkg::keep_t     tail_keep;
    logic                  is_last;

    assign last_idx  = (rd_len - 1'b1) >> 3;        // Final beat number
    // Stop at the slot end as well
    assign is_last   = (pf_cfg_pkg::pkt_len_t'(beat_cnt) == last_idx) ||
                       (32'(beat_cnt) >= MAX_BEATS - 1);
    assign tail_keep = (rd_len[2:0] == 3'd0) ? '1 :
                       pf_cfg_pkg::keep_t'((9'd1 << rd_len[2:0]) - 9'd1);

    assign rd_en      = (state == s_fetch);
    assign rd_addr    = beat_cnt;
    assign fwd_tvalid = (state == s_present);
    assign fwd_tdata  = rd_data;                    // Read register holds during stall
    assign fwd_tkeep  = is_last ? tail_keep : '1;
    assign fwd_tlast  = fwd_tvalid & is_last;
    assign rd_release = fwd_tvalid & fwd_tready & is_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= s_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (rd_full) begin
                        beat_cnt <= '0;
                        state    <= s_fetch;
                    end
                end
                s_fetch: state <= s_present;        // Data lands next cycle
                s_present: begin
                    if (fwd_tready) begin
                        if (is_last) begin
                            state <= s_idle;        // Slot released this edge
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            state    <= s_fetch;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

/* hdl/pf_top.sv */
`timescale 1ns/1ps

module pf_top #(
    parameter int N_RULES   = 8,
    parameter int MAX_BEATS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  pf_cfg_pkg::data_t       sn_tdata,
    input  pf_cfg_pkg::keep_t       sn_tkeep,
    input  logic                    sn_tvalid,
    input  logic                    sn_tready,
    input  logic                    sn_tlast,
    output pf_cfg_pkg::data_t       fwd_tdata,
    output pf_cfg_pkg::keep_t       fwd_tkeep,
    output logic                    fwd_tlast,
    output logic                    fwd_tvalid,
    input  logic                    fwd_tready,
    input  pf_rule_pkg::rule_addr_t inst_wr_addr,
    input  pf_rule_pkg::rule_word_t inst_wr_data,
    input  logic                    inst_wr_en,
    output pf_cfg_pkg::drop_cnt_t   num_packets_dropped
);

    // Snooper to matcher and buffer
    logic                    beat_valid;
    pf_cfg_pkg::data_t       beat_data;
    pf_cfg_pkg::beat_idx_t   beat_idx;
    pf_cfg_pkg::beat_bytes_t beat_bytes;
    logic                    beat_last;
    logic                    overflow;
    // Verdict and slot handshakes
    logic                    accept;
    logic                    reject;
    logic                    slot_free;
    // Buffer read side
    logic                    rd_full;
    pf_cfg_pkg::pkt_len_t    rd_len;
    pf_cfg_pkg::data_t       rd_data;
    logic                    rd_en;
    pf_cfg_pkg::beat_idx_t   rd_addr;
    logic                    rd_release;

    pf_snooper #(.MAX_BEATS(MAX_BEATS)) u_snooper (
        .clk, .rst_n, .start, .sn_tdata, .sn_tkeep, .sn_tvalid, .sn_tready, .sn_tlast,
        .slot_free, .beat_valid, .beat_data, .beat_idx, .beat_bytes, .beat_last, .overflow
    );

    pf_rule_matcher #(.N_RULES(N_RULES)) u_matcher (
        .clk, .rst_n, .inst_wr_addr, .inst_wr_data, .inst_wr_en,
        .beat_valid, .beat_data, .beat_idx, .beat_bytes, .beat_last, .overflow,
        .accept, .reject, .num_packets_dropped
    );

    pf_packet_buffer #(.MAX_BEATS(MAX_BEATS)) u_buffer (
        .clk, .rst_n, .beat_valid, .beat_data, .beat_idx, .beat_bytes, .beat_last,
        .accept, .rd_release, .rd_en, .rd_addr, .slot_free, .rd_full, .rd_len, .rd_data
    );

    pf_forwarder #(.MAX_BEATS(MAX_BEATS)) u_forwarder (
        .clk, .rst_n, .rd_full, .rd_len, .rd_data, .fwd_tready,
        .rd_en, .rd_addr, .rd_release, .fwd_tdata, .fwd_tkeep, .fwd_tlast, .fwd_tvalid
    );

endmodule

/* verif/pf_tb.sv */
`timescale 1ns/1ps

module pf_tb;

    localparam int N_RULES   = 8;
    localparam int MAX_BEATS = 32;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    start;
    pf_cfg_pkg::data_t       sn_tdata;
    pf_cfg_pkg::keep_t       sn_tkeep;
    logic                    sn_tvalid;
    logic                    sn_tready;
    logic                    sn_tlast;
    pf_cfg_pkg::data_t       fwd_tdata;
    pf_cfg_pkg::keep_t       fwd_tkeep;
    logic                    fwd_tlast;
    logic                    fwd_tvalid;
    logic                    fwd_tready = 1'b1;
    pf_rule_pkg::rule_addr_t inst_wr_addr;
    pf_rule_pkg::rule_word_t inst_wr_data;
    logic                    inst_wr_en;
    pf_cfg_pkg::drop_cnt_t   num_packets_dropped;

    logic [7:0]  pkt [256];                         // Packet being sent
    logic        rule_v [N_RULES];                  // Model copy of the rule table
    logic [7:0]  rule_ofs [N_RULES];
    logic [7:0]  rule_mask [N_RULES];
    logic [7:0]  rule_val [N_RULES];
    logic [7:0]  exp_bytes [$];                     // Expected output bytes, in order
    int          exp_lens [$];                      // Remaining bytes per expected packet
    pf_cfg_pkg::drop_cnt_t drops_exp;
    logic [31:0] seed = 32'h35ae_52fa;
    logic [31:0] ready_seed = 32'h35ae_52fa;        // Separate stream for tready
    logic [1:0]  ready_mode;                        // 0 low, 1 high, 2 random
    int          mon_rem;
    int          mon_n;
    pf_cfg_pkg::data_t mon_data;
    pf_cfg_pkg::data_t mon_mask;
    pf_cfg_pkg::keep_t mon_keep;

    pf_top #(.N_RULES(N_RULES), .MAX_BEATS(MAX_BEATS)) u_dut (.*);

    always #20 clk = ~clk;                          // 40 ns period

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] rand_byte();
        seed = lcg_step(seed);
        return seed[31:24];                         // Upper bits are the most random
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input pf_cfg_pkg::data_t got, exp);
        if (got !== exp) begin
            abort($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_keep(input string name, input pf_cfg_pkg::keep_t got, exp);
        if (got !== exp) begin
            abort($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input pf_cfg_pkg::drop_cnt_t got, exp);
        if (got !== exp) begin
            abort($sformatf("error at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            abort($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Accepted when every valid rule sees its byte inside the packet and matches
    function automatic bit rules_pass(input int len);
        for (int r = 0; r < N_RULES; r++) begin
            if (rule_v[r]) begin
                if (int'(rule_ofs[r]) >= len) return 1'b0;
                if ((pkt[rule_ofs[r]] & rule_mask[r]) != (rule_val[r] & rule_mask[r])) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Mode 1 forces all reachable rules to match and mode 2 then breaks the first one
    function automatic void shape_packet(input int len, input int mode);
        bit flipped;
        flipped = 1'b0;
        for (int r = 0; r < N_RULES; r++) begin
            if (mode != 0 && rule_v[r] && int'(rule_ofs[r]) < len) begin
                pkt[rule_ofs[r]] = (pkt[rule_ofs[r]] & ~rule_mask[r]) |
                                   (rule_val[r] & rule_mask[r]);
            end
        end
        for (int r = 0; r < N_RULES; r++) begin
            if (mode == 2 && !flipped && rule_v[r] && int'(rule_ofs[r]) < len &&
                rule_mask[r] != 0) begin
                pkt[rule_ofs[r]] = pkt[rule_ofs[r]] ^ rule_mask[r];
                flipped = 1'b1;
            end
        end
    endfunction

    task automatic write_rule(input int idx, input logic v, input logic [7:0] ofs, mask, val);
        pf_rule_pkg::rule_word_t w;
        w = '0;
        w[pf_rule_pkg::RULE_VALID_BIT]      = v;
        w[pf_rule_pkg::RULE_OFS_LSB +: 8]   = ofs;
        w[pf_rule_pkg::RULE_MASK_LSB +: 8]  = mask;
        w[pf_rule_pkg::RULE_VAL_LSB +: 8]   = val;
        rule_v[idx]    = v;
        rule_ofs[idx]  = ofs;
        rule_mask[idx] = mask;
        rule_val[idx]  = val;
        @(posedge clk);
        inst_wr_en   <= 1'b1;
        inst_wr_addr <= pf_rule_pkg::rule_addr_t'(idx);
        inst_wr_data <= w;
        @(posedge clk);
        inst_wr_en   <= 1'b0;
    endtask

    task automatic clear_rules();
        for (int i = 0; i < N_RULES; i++) write_rule(i, 1'b0, 8'h00, 8'h00, 8'h00);
    endtask

    task automatic set_ready(input logic [1:0] mode);
        @(posedge clk);
        ready_mode <= mode;
    endtask

    // Gated sends keep at most one accepted packet outstanding
    task automatic send_packet(input int len, input int mode, input bit gated);
        int t;
        pf_cfg_pkg::data_t d;
        pf_cfg_pkg::keep_t k;
        for (int i = 0; i < len; i++) pkt[i] = rand_byte();
        shape_packet(len, mode);
        t = 0;
        while (gated && exp_lens.size() > 1) begin
            @(posedge clk);
            t++;
            if (t > 5000) abort("timeout while waiting for a free packet slot");
        end
        if (start) begin                            // Ignored entirely while stopped
            if (exp_lens.size() >= 2 || !rules_pass(len)) begin
                drops_exp = drops_exp + 16'd1;      // Overflow or rejected
            end else begin
                exp_lens.push_back(len);
                for (int i = 0; i < len; i++) exp_bytes.push_back(pkt[i]);
            end
        end
        for (int b = 0; b * 8 < len; b++) begin
            for (int i = 0; i < 8; i++) begin
                k[i] = (b * 8 + i < len);
                d[i*8 +: 8] = k[i] ? pkt[b*8+i] : 8'h00;
            end
            @(posedge clk);
            sn_tvalid <= 1'b1;
            sn_tready <= 1'b1;
            sn_tdata  <= d;
            sn_tkeep  <= k;
            sn_tlast  <= (b * 8 + 8 >= len);
        end
        @(posedge clk);
        sn_tvalid <= 1'b0;
        sn_tready <= 1'b0;
        sn_tlast  <= 1'b0;
        @(posedge clk);                             // Verdict lands on this edge
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_lens.size() != 0) begin
            @(posedge clk);
            t++;
            if (t > 5000) abort("timeout while waiting for packets on the forwarding port");
        end
        @(negedge clk);
        check_count("num_packets_dropped", num_packets_dropped, drops_exp);
    endtask

    task automatic test_empty_rules();
        clear_rules();
        for (int len = 1; len <= 40; len++) send_packet(len, 0, 1'b1);
        wait_drain();
    endtask

    task automatic test_rule_verdicts();
        write_rule(0, 1'b1, 8'd0, 8'hff, 8'ha5);
        write_rule(1, 1'b1, 8'd9, 8'hff, 8'h3c);
        send_packet(16, 1, 1'b1);
        send_packet(16, 2, 1'b1);                   // Byte 0 wrong
        send_packet(12, 1, 1'b1);
        wait_drain();
    endtask

    task automatic test_masks_and_offsets();
        clear_rules();
        write_rule(2, 1'b1, 8'd3, 8'hf0, 8'h5c);    // Upper nibble only
        write_rule(5, 1'b1, 8'd30, 8'h0f, 8'h07);
        write_rule(6, 1'b1, 8'd12, 8'h00, 8'hff);   // Byte must merely exist
        send_packet(20, 1, 1'b1);                   // Offset 30 past the end
        send_packet(31, 1, 1'b1);
        send_packet(40, 2, 1'b1);
        send_packet(10, 1, 1'b1);                   // Offset 12 past the end
        for (int i = 0; i < 6; i++) send_packet(33 + i, 0, 1'b1);
        wait_drain();
    endtask

    task automatic test_overflow();
        clear_rules();
        set_ready(2'd0);
        send_packet(24, 0, 1'b0);
        send_packet(9, 0, 1'b0);
        send_packet(17, 0, 1'b0);                   // Both slots full by now
        @(negedge clk);
        check_count("num_packets_dropped", num_packets_dropped, drops_exp);
        set_ready(2'd1);
        wait_drain();
    endtask

    task automatic test_random_ready();
        clear_rules();
        write_rule(3, 1'b1, 8'd0, 8'h01, 8'h00);    // Even first byte passes
        set_ready(2'd2);
        for (int n = 0; n < 30; n++) send_packet(1 + int'(rand_byte()) % 40, 0, 1'b1);
        wait_drain();
        set_ready(2'd1);
    endtask

    task automatic test_start_low();
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);                             // Stopped before the first beat
        send_packet(8, 0, 1'b1);
        send_packet(30, 1, 1'b1);
        send_packet(3, 2, 1'b1);
        repeat (20) @(posedge clk);                 // Quiet window with nothing forwarded
        start <= 1'b1;
        @(posedge clk);
        send_packet(16, 1, 1'b1);
        wait_drain();
    endtask

    always @(posedge clk) begin
        if (ready_mode == 2'd2) begin
            ready_seed = lcg_step(ready_seed);
            fwd_tready <= ready_seed[31];
        end else begin
            fwd_tready <= ready_mode[0];
        end
    end

    // Output monitor checks every accepted beat
    always @(posedge clk) begin
        if (rst_n && fwd_tvalid && fwd_tready) begin
            if (exp_lens.size() == 0) begin
                abort("a beat was forwarded while no packet was expected");
            end else begin
                mon_rem  = exp_lens[0];
                mon_n    = (mon_rem > 8) ? 8 : mon_rem;
                mon_keep = '0;
                mon_data = '0;
                mon_mask = '0;
                for (int i = 0; i < mon_n; i++) begin
                    mon_keep[i]        = 1'b1;
                    mon_data[i*8 +: 8] = exp_bytes[i];
                    mon_mask[i*8 +: 8] = 8'hff;
                end
                check_keep("fwd_tkeep", fwd_tkeep, mon_keep);
                check_data("fwd_tdata", fwd_tdata & mon_mask, mon_data);
                check_flag("fwd_tlast", fwd_tlast, mon_rem <= 8);
                for (int i = 0; i < mon_n; i++) void'(exp_bytes.pop_front());
                if (mon_rem <= 8) void'(exp_lens.pop_front());
                else exp_lens[0] = mon_rem - 8;
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        start        = 1'b1;
        sn_tdata     = '0;
        sn_tkeep     = '0;
        sn_tvalid    = 1'b0;
        sn_tready    = 1'b0;
        sn_tlast     = 1'b0;
        inst_wr_addr = '0;
        inst_wr_data = '0;
        inst_wr_en   = 1'b0;
        ready_mode   = 2'd1;
        drops_exp    = '0;
        for (int i = 0; i < N_RULES; i++) rule_v[i] = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_empty_rules();
        test_rule_verdicts();
        test_masks_and_offsets();
        test_overflow();
        test_random_ready();
        test_start_low();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* list.f */
hdl/pf_cfg_pkg.sv
hdl/pf_rule_pkg.sv
hdl/pf_snooper.sv
hdl/pf_rule_matcher.sv
hdl/pf_packet_buffer.sv
hdl/pf_forwarder.sv
hdl/pf_top.sv
verif/pf_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pf_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
